//--- raster_unit.f
rtl/raster_pkg.sv
rtl/shape_decode.sv
rtl/pixel_scan.sv
rtl/frame_store.sv
rtl/raster_unit.sv
bench/raster_unit_tb.sv

//--- Makefile
# Verilator build and run of the raster unit testbench
SIM := obj_dir/Vraster_unit_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): raster_unit.f $(wildcard rtl/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f raster_unit.f \
		--top-module raster_unit_tb -Mdir obj_dir

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/raster_golden.txt
# Raster unit stimulus for a 64 x 48 screen, one record per line
# T test | D or I shape(0 rect, 1 circle) color x y width height_radius erase
# C x y expected_color | R random pixel count vs model | F whole frame vs model
# I queues a start that is pulsed while the next D is busy
T 1
C 0 0 0
C 63 47 0
R 6
T 2
D 0 1 10 5 4 3 0
C 10 5 1
C 13 7 1
C 9 5 0
C 14 7 0
C 10 4 0
C 10 8 0
T 3
D 1 2 30 20 0 5 0
C 30 20 2
C 35 20 2
C 34 23 2
C 34 24 0
C 36 20 0
R 8
T 4
D 0 3 60 45 10 10 0
C 63 47 3
C 0 45 0
C 60 0 0
D 1 1 2 2 0 4 0
C 0 0 1
C 6 2 1
C 5 5 0
C 62 0 0
D 0 2 20 30 0 5 0
C 20 30 0
T 5
D 0 0 28 18 5 5 1
C 30 20 0
C 33 20 2
D 0 3 12 6 4 4 0
C 12 6 3
C 11 6 1
C 12 5 1
T 6
I 0 2 0 20 20 20 0
D 1 3 50 10 0 3 0
C 10 25 0
C 50 10 3
F

//--- bench/raster_unit_tb.sv
`timescale 1ns/1ps

module raster_unit_tb;

    localparam int H_PIX = 64;
    localparam int V_PIX = 48;
    localparam int FRAME = H_PIX * V_PIX;       // Also the clear sweep length

    logic                           clk;
    logic                           rst_n;
    raster_pkg::raster_cmd_t        cmd;
    logic                           start;
    logic [raster_pkg::X_W-1:0]     rd_x;
    logic [raster_pkg::Y_W-1:0]     rd_y;
    logic                           busy;
    logic                           done;
    logic [raster_pkg::COLOR_W-1:0] rd_color;
    logic                           ready;

    logic [1:0]              shadow [V_PIX][H_PIX];  // Expected frame indexed [row][column]
    int                      errors = 0;
    int                      checks = 0;
    int                      tests = 0;
    int                      test_id = -1;           // No test open yet
    int                      test_errors = 0;
    int                      test_checks = 0;
    int unsigned             lcg_state = 63179;
    int                      budget = FRAME + 200;   // Watchdog cycles grown per record
    int                      wd_cycles = 0;
    bit                      done_level = 1'b0;      // done expected before next start
    bit                      ghost_pending = 1'b0;   // Start to pulse while busy
    raster_pkg::raster_cmd_t ghost_cmd;

    raster_unit #(.H_PIXELS(H_PIX), .V_PIXELS(V_PIX)) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .start    (start),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .busy     (busy),
        .done     (done),
        .rd_color (rd_color),
        .ready    (ready)
    );

    always #20 clk = ~clk;                      // 40 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_id >= 0) begin
            $display("test %0d %s: %0d checks, %0d mismatches", test_id,
                     (test_errors == 0) ? "ok" : "not ok", test_checks, test_errors);
            tests++;
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic golden_error(input string what);
        $display("Golden file problem: %s", what);
        errors++;
    endtask

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic raster_pkg::raster_cmd_t make_cmd(input int shape, input int color,
            input int x, input int y, input int width, input int hr, input int erase);
        raster_pkg::raster_cmd_t c;
        c.shape         = raster_pkg::shape_e'(shape[1:0]);
        c.color         = color[1:0];
        c.x             = x[raster_pkg::X_W-1:0];
        c.y             = y[raster_pkg::Y_W-1:0];
        c.width         = width[raster_pkg::X_W-1:0];
        c.height_radius = hr[raster_pkg::Y_W-1:0];
        c.erase         = erase[0];
        return c;
    endfunction

    // Inclusive on-screen box of a command that returns 1 when nothing is left
    function automatic bit clip_box(input raster_pkg::raster_cmd_t c,
                                    output int x0, output int x1,
                                    output int y0, output int y1);
        int r;
        bit circle;
        r = int'(c.height_radius);
        circle = c.shape == raster_pkg::SHAPE_CIRCLE;
        if (circle) begin
            x0 = (int'(c.x) > r) ? int'(c.x) - r : 0;   // Left and top stop at 0
            x1 = int'(c.x) + r;
            y0 = (int'(c.y) > r) ? int'(c.y) - r : 0;
            y1 = int'(c.y) + r;
        end else begin
            x0 = int'(c.x);
            x1 = int'(c.x) + int'(c.width) - 1;
            y0 = int'(c.y);
            y1 = int'(c.y) + r - 1;
        end
        if (x1 > H_PIX - 1)
            x1 = H_PIX - 1;
        if (y1 > V_PIX - 1)
            y1 = V_PIX - 1;
        return x0 >= H_PIX || y0 >= V_PIX || (!circle && (c.width == 0 || r == 0));
    endfunction

    // Cycles from start edge to done edge as two plus one per box pixel
    function automatic int draw_cycles(input raster_pkg::raster_cmd_t c);
        int x0, x1, y0, y1;
        if (clip_box(c, x0, x1, y0, y1))
            return 2;
        return 2 + (x1 - x0 + 1) * (y1 - y0 + 1);
    endfunction

    task automatic paint_shadow(input raster_pkg::raster_cmd_t c);
        int x0, x1, y0, y1;
        int dx, dy, r;
        if (clip_box(c, x0, x1, y0, y1))
            return;
        r = int'(c.height_radius);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                dx = x - int'(c.x);
                dy = y - int'(c.y);
                if (c.shape != raster_pkg::SHAPE_CIRCLE || dx * dx + dy * dy <= r * r)
                    shadow[y][x] = c.erase ? 2'd0 : c.color;    // Last write wins
            end
        end
    endtask

    // Address set after a falling edge and data registered at the next rising edge
    task automatic check_pixel(input int x, input int y, input logic [1:0] exp);
        rd_x = x[raster_pkg::X_W-1:0];
        rd_y = y[raster_pkg::Y_W-1:0];
        @(negedge clk);
        check_value($sformatf("rd_color[%0d,%0d]", x, y), rd_color, exp);
    endtask

    task automatic run_draw(input raster_pkg::raster_cmd_t c);
        int lat;
        check_value("done", done, done_level);   // Held from the previous command
        check_value("busy", busy, 0);
        cmd   = c;
        start = 1'b1;
        @(negedge clk);                          // Start taken at the edge before
        start = 1'b0;
        check_value("busy", busy, 1);
        check_value("done", done, 0);
        lat = 0;
        while (!done) begin
            if (lat == 1 && ghost_pending) begin
                check_value("busy", busy, 1);
                cmd           = ghost_cmd;       // Must be dropped by the DUT
                start         = 1'b1;
                ghost_pending = 1'b0;
            end
            @(negedge clk);
            start = 1'b0;
            lat++;
        end
        check_value("done_cycles", lat, draw_cycles(c));
        check_value("busy", busy, 0);
        paint_shadow(c);
        done_level = 1'b1;
    endtask

    // Watchdog whose limit grows as records are read
    initial begin
        while (wd_cycles < budget) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("Timeout: simulation made no progress within %0d clock cycles", wd_cycles);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        int fd;
        int n;
        int op;
        int ch;
        int f [7];
        int cycles;
        clk   = 1'b0;
        rst_n = 1'b0;
        cmd   = '0;
        start = 1'b0;
        rd_x  = '0;
        rd_y  = '0;
        foreach (shadow[y, x])
            shadow[y][x] = 2'd0;                 // Frame after the clear sweep

        // Reset levels and clear sweep length
        test_id = 0;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("ready", ready, 0);
        repeat (3) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!ready) begin
            @(negedge clk);
            cycles++;
        end
        check_value("ready_cycles", cycles, FRAME);
        close_test();

        fd = $fopen("bench/raster_golden.txt", "r");
        if (fd == 0) begin
            golden_error("cannot open bench/raster_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, " %c", op);
                if (n != 1)
                    break;
                case (op)
                    "#": begin
                        ch = $fgetc(fd);             // Comment runs to end of line
                        while (ch != "\n" && ch != -1)
                            ch = $fgetc(fd);
                    end
                    "T": begin
                        n = $fscanf(fd, "%d", f[0]);
                        close_test();
                        if (n != 1)
                            golden_error("test record without a number");
                        test_id = f[0];
                    end
                    "D", "I": begin
                        n = $fscanf(fd, "%d %d %d %d %d %d %d",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                        if (n != 7) begin
                            golden_error("command record with missing fields");
                        end else if (op == "I") begin
                            ghost_cmd     = make_cmd(f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                            ghost_pending = 1'b1;
                        end else begin
                            budget += FRAME + 10;
                            run_draw(make_cmd(f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
                        end
                    end
                    "C": begin
                        n = $fscanf(fd, "%d %d %d", f[0], f[1], f[2]);
                        budget += 4;
                        if (n != 3)
                            golden_error("pixel record with missing fields");
                        else
                            check_pixel(f[0], f[1], f[2][1:0]);
                    end
                    "R": begin
                        n = $fscanf(fd, "%d", f[0]);
                        if (n != 1) begin
                            golden_error("random record without a count");
                        end else begin
                            budget += 4 * f[0] + 4;
                            for (int i = 0; i < f[0]; i++) begin
                                lcg_state = lcg_next(lcg_state);
                                f[1] = int'((lcg_state >> 16) % H_PIX);
                                lcg_state = lcg_next(lcg_state);
                                f[2] = int'((lcg_state >> 16) % V_PIX);
                                check_pixel(f[1], f[2], shadow[f[2]][f[1]]);
                            end
                        end
                    end
                    "F": begin
                        budget += FRAME + 4;          // Every pixel against the model
                        foreach (shadow[y, x])
                            check_pixel(x, y, shadow[y][x]);
                    end
                    default: begin
                        golden_error($sformatf("unknown record type '%c'", op));
                        ch = $fgetc(fd);
                        while (ch != "\n" && ch != -1)
                            ch = $fgetc(fd);
                    end
                endcase
            end
            $fclose(fd);
        end
        close_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- rtl/raster_unit.sv
`timescale 1ns/1ps

module raster_unit #(
    parameter int H_PIXELS = 640,
    parameter int V_PIXELS = 480
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  raster_pkg::raster_cmd_t        cmd,
    input  logic                           start,     // One-cycle strobe
    input  logic [raster_pkg::X_W-1:0]     rd_x,
    input  logic [raster_pkg::Y_W-1:0]     rd_y,
    output logic                           busy,
    output logic                           done,
    output logic [raster_pkg::COLOR_W-1:0] rd_color,
    output logic                           ready      // Low during clear sweep
);

    raster_pkg::scan_box_t box;        // Decode to execute
    logic                  box_valid;
    raster_pkg::pixel_wr_t wr;         // Execute to frame store
    logic                  scan_last;

    // Decode stage with command latch, clipping, busy and done
    shape_decode #(.H_PIXELS(H_PIXELS), .V_PIXELS(V_PIXELS)) u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .start     (start),
        .ready     (ready),
        .scan_last (scan_last),
        .box       (box),
        .box_valid (box_valid),
        .busy      (busy),
        .done      (done)
    );

    // Execute stage walking the box and testing coverage
    pixel_scan #(.H_PIXELS(H_PIXELS), .V_PIXELS(V_PIXELS)) u_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .box       (box),
        .box_valid (box_valid),
        .wr        (wr),
        .scan_last (scan_last)
    );

    // Result stage holding the frame memory, clear sweep and read port
    frame_store #(.H_PIXELS(H_PIXELS), .V_PIXELS(V_PIXELS)) u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_color (rd_color),
        .ready    (ready)
    );

endmodule

//--- rtl/frame_store.sv
`timescale 1ns/1ps

module frame_store #(
    parameter int H_PIXELS = 640,
    parameter int V_PIXELS = 480
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  raster_pkg::pixel_wr_t             wr,
    input  logic [raster_pkg::X_W-1:0]        rd_x,
    input  logic [raster_pkg::Y_W-1:0]        rd_y,
    output logic [raster_pkg::COLOR_W-1:0]    rd_color,
    output logic                              ready
);

    typedef enum logic {
        STORE_CLEAR,
        STORE_READY
    } store_state_e;

    localparam int DEPTH  = H_PIXELS * V_PIXELS;
    localparam int ADDR_W = $clog2(DEPTH);

    store_state_e                   state;
    logic [raster_pkg::COLOR_W-1:0] mem [DEPTH];      // One entry per pixel
    logic [ADDR_W-1:0]              clr_addr;         // Sweep pointer
    logic [ADDR_W-1:0]              wr_addr;
    logic [ADDR_W-1:0]              rd_addr;
    logic                           rd_in_range;

    // Single write port shared by sweep and drawing
    logic                           mem_we;
    logic [ADDR_W-1:0]              mem_addr;
    logic [raster_pkg::COLOR_W-1:0] mem_data;

    assign ready = state == STORE_READY;

    // Row-major addressing with the screen width as stride
    assign wr_addr = ADDR_W'(int'(wr.y) * H_PIXELS + int'(wr.x));
    assign rd_addr = ADDR_W'(int'(rd_y) * H_PIXELS + int'(rd_x));
    assign rd_in_range = (int'(rd_x) < H_PIXELS) && (int'(rd_y) < V_PIXELS);

    always_comb begin
        if (state == STORE_CLEAR) begin
            mem_we   = 1'b1;                 // Clear one pixel per cycle
            mem_addr = clr_addr;
            mem_data = '0;
        end else begin
            mem_we   = wr.valid;
            mem_addr = wr_addr;
            mem_data = wr.color;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= STORE_CLEAR;
            clr_addr <= '0;
        end else if (state == STORE_CLEAR) begin
            if (clr_addr == ADDR_W'(DEPTH - 1))
                state <= STORE_READY;        // Whole frame now colour 0
            else
                clr_addr <= clr_addr + 1'b1;
        end
    end

    // Pixel memory
    always_ff @(posedge clk) begin
        if (mem_we)
            mem[mem_addr] <= mem_data;
    end

    // Registered read where off-screen addresses return background
    always_ff @(posedge clk) begin
        rd_color <= rd_in_range ? mem[rd_addr] : '0;
    end

    // Decode holds starts back until the sweep is done
    a_no_wr_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
        !ready |-> !wr.valid);

endmodule

//--- rtl/pixel_scan.sv
`timescale 1ns/1ps

module pixel_scan #(
    parameter int H_PIXELS = 640,
    parameter int V_PIXELS = 480
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  raster_pkg::scan_box_t box,
    input  logic                  box_valid,
    output raster_pkg::pixel_wr_t wr,
    output logic                  scan_last
);

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_END
    } scan_state_e;

    scan_state_e           state;
    raster_pkg::scan_box_t box_q;              // Box held for the whole scan
    logic [raster_pkg::X_W-1:0] x_cnt;         // Current column
    logic [raster_pkg::Y_W-1:0] y_cnt;         // Current row
    logic                  last_col;
    logic                  last_row;

    // Circle test operands
    logic signed [raster_pkg::X_W:0] dx;
    logic signed [raster_pkg::Y_W:0] dy;
    logic [21:0]           dist_sq;            // Sum of squares dx^2 + dy^2
    logic                  in_circle;
    logic                  covered;

    assign last_col = x_cnt == box_q.x_max;
    assign last_row = y_cnt == box_q.y_max;

    // Offsets from centre with one extra sign bit
    assign dx = $signed({1'b0, x_cnt}) - $signed({1'b0, box_q.cx});
    assign dy = $signed({1'b0, y_cnt}) - $signed({1'b0, box_q.cy});

    assign dist_sq   = dx * dx + dy * dy;
    assign in_circle = dist_sq <= 22'(box_q.r_sq);

    // Rectangles cover the whole clipped box
    assign covered = (box_q.shape == raster_pkg::SHAPE_CIRCLE) ? in_circle : 1'b1;

    // Last write is in flight while in SCAN_END
    assign scan_last = state == SCAN_END;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SCAN_IDLE;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (box_valid)
                        state <= box.empty ? SCAN_END : SCAN_RUN;   // Empty box skips the walk
                end
                SCAN_RUN: begin
                    if (last_col && last_row)
                        state <= SCAN_END;
                end
                SCAN_END: begin
                    state <= SCAN_IDLE;
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Box and counters for the current scan
    always_ff @(posedge clk) begin
        if (state == SCAN_IDLE && box_valid) begin
            box_q <= box;
            x_cnt <= box.x_min;                 // Start at top-left of box
            y_cnt <= box.y_min;
        end else if (state == SCAN_RUN) begin
            if (last_col) begin
                x_cnt <= box_q.x_min;           // Wrap to next row
                if (!last_row)
                    y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;          // x runs fastest
            end
        end
    end

    // One registered write per scanned pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr <= '0;
        end else begin
            wr.valid <= state == SCAN_RUN && covered;
            wr.x     <= x_cnt;
            wr.y     <= y_cnt;
            wr.color <= box_q.color;
        end
    end

    // Clipping in decode keeps every write on screen
    a_wr_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        wr.valid |-> (int'(wr.x) < H_PIXELS) && (int'(wr.y) < V_PIXELS));

endmodule

//--- rtl/shape_decode.sv
`timescale 1ns/1ps

module shape_decode #(
    parameter int H_PIXELS = 640,
    parameter int V_PIXELS = 480
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  raster_pkg::raster_cmd_t cmd,
    input  logic                    start,
    input  logic                    ready,      // Clear sweep finished
    input  logic                    scan_last,  // Execute stage wrote its last pixel
    output raster_pkg::scan_box_t   box,
    output logic                    box_valid,
    output logic                    busy,
    output logic                    done
);

    typedef enum logic {
        CMD_IDLE,
        CMD_ACTIVE
    } cmd_state_e;

    // Last valid column and row with one bit of headroom
    localparam logic [raster_pkg::X_W:0] X_LAST = (raster_pkg::X_W + 1)'(H_PIXELS - 1);
    localparam logic [raster_pkg::Y_W:0] Y_LAST = (raster_pkg::Y_W + 1)'(V_PIXELS - 1);

    cmd_state_e              state;
    raster_pkg::raster_cmd_t cmd_q;           // Latched command
    logic                    accept;
    logic                    is_circle;
    logic [raster_pkg::X_W:0] x_lo, x_hi;    // Unclamped box with carry bit
    logic [raster_pkg::Y_W:0] y_lo, y_hi;
    logic [raster_pkg::X_W:0] cx_w, r_x;     // Zero-extended operands
    logic [raster_pkg::Y_W:0] cy_w, r_y;

    // Idle, not holding a pending box, and the frame is cleared
    assign accept    = start && ready && state == CMD_IDLE && !box_valid;
    assign busy      = box_valid || state == CMD_ACTIVE;
    assign is_circle = cmd_q.shape == raster_pkg::SHAPE_CIRCLE;

    assign cx_w = {1'b0, cmd_q.x};
    assign cy_w = {1'b0, cmd_q.y};
    assign r_x  = {2'b00, cmd_q.height_radius};
    assign r_y  = {1'b0, cmd_q.height_radius};

    // Bounding box before clipping to the right and bottom edges
    always_comb begin
        if (is_circle) begin
            x_lo = (cx_w >= r_x) ? cx_w - r_x : '0;   // Clamp at column 0
            x_hi = cx_w + r_x;
            y_lo = (cy_w >= r_y) ? cy_w - r_y : '0;   // Clamp at row 0
            y_hi = cy_w + r_y;
        end else begin
            x_lo = cx_w;
            x_hi = cx_w + {1'b0, cmd_q.width} - 1'b1;  // Wraps on zero width and is flagged empty
            y_lo = cy_w;
            y_hi = cy_w + r_y - 1'b1;
        end
    end

    // Clipped box built from the latched command
    always_comb begin
        box.x_min = x_lo[raster_pkg::X_W-1:0];
        box.y_min = y_lo[raster_pkg::Y_W-1:0];
        box.x_max = (x_hi > X_LAST) ? X_LAST[raster_pkg::X_W-1:0] : x_hi[raster_pkg::X_W-1:0];
        box.y_max = (y_hi > Y_LAST) ? Y_LAST[raster_pkg::Y_W-1:0] : y_hi[raster_pkg::Y_W-1:0];
        box.cx    = cmd_q.x;
        box.cy    = cmd_q.y;
        box.r_sq  = {9'd0, cmd_q.height_radius} * {9'd0, cmd_q.height_radius};
        box.shape = cmd_q.shape;
        box.color = cmd_q.erase ? '0 : cmd_q.color;       // Erase paints background
        box.empty = (x_lo > X_LAST) || (y_lo > Y_LAST)
                 || (!is_circle && (cmd_q.width == '0 || cmd_q.height_radius == '0));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CMD_IDLE;
            box_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            box_valid <= accept;                // One-cycle pulse after acceptance
            if (accept)
                done <= 1'b0;                   // Drops on the next accepted start
            case (state)
                CMD_IDLE: begin
                    if (box_valid)
                        state <= CMD_ACTIVE;    // Box now owned by the scanner
                end
                CMD_ACTIVE: begin
                    if (scan_last) begin
                        state <= CMD_IDLE;
                        done  <= 1'b1;          // Rises as the last write lands
                    end
                end
            endcase
        end
    end

    // Command payload held from the accepted start
    always_ff @(posedge clk) begin
        if (accept)
            cmd_q <= cmd;
    end

    // No new box while the scanner still owns one
    a_box_once: assert property (@(posedge clk) disable iff (!rst_n)
        box_valid |-> state == CMD_IDLE);

    // Scanner only finishes work that this stage gave it
    a_last_owned: assert property (@(posedge clk) disable iff (!rst_n)
        scan_last |-> state == CMD_ACTIVE);

endmodule

//--- rtl/raster_pkg.sv
package raster_pkg;

    // Coordinate and colour widths for screens up to 1024 x 512
    localparam int X_W     = 10;            // Column along the wide axis
    localparam int Y_W     = 9;             // Row
    localparam int COLOR_W = 2;             // 2 bits per pixel
    localparam int RSQ_W   = 2 * Y_W;       // Radius squared

    // Drawing opcodes in a 2-bit select field
    typedef enum logic [1:0] {
        SHAPE_RECT   = 2'b00,
        SHAPE_CIRCLE = 2'b01
    } shape_e;

    // One drawing command as presented at the start strobe (43 bits)
    typedef struct packed {
        shape_e             shape;          // Rectangle or circle
        logic [COLOR_W-1:0] color;          // Fill colour
        logic [X_W-1:0]     x;              // Left edge or centre column
        logic [Y_W-1:0]     y;              // Top edge or centre row
        logic [X_W-1:0]     width;          // Rectangle only
        logic [Y_W-1:0]     height_radius;  // Rectangle height or circle radius
        logic               erase;          // Write colour 0 instead
    } raster_cmd_t;

    // Clipped scan box handed from decode to execute
    typedef struct packed {
        logic [X_W-1:0]     x_min;          // Inclusive on-screen bounds
        logic [X_W-1:0]     x_max;
        logic [Y_W-1:0]     y_min;
        logic [Y_W-1:0]     y_max;
        logic [X_W-1:0]     cx;             // Circle centre
        logic [Y_W-1:0]     cy;
        logic [RSQ_W-1:0]   r_sq;           // Circle radius squared
        shape_e             shape;
        logic [COLOR_W-1:0] color;          // Zero when erasing
        logic               empty;          // Nothing left after clipping
    } scan_box_t;

    // Single pixel write into the frame store
    typedef struct packed {
        logic               valid;
        logic [X_W-1:0]     x;
        logic [Y_W-1:0]     y;
        logic [COLOR_W-1:0] color;
    } pixel_wr_t;

endpackage
